// File: verif/xlate_input.txt
# C da plv datm asid dmw0 dmw1 | T idx vppn ps4m g asid ppn0 v0 d0 plv0 mat0 ppn1 v1 d1 plv1 mat1
# R vaddr store fault word mat | B hold | Q acceptances | F release | I cycles (hex)
C 1 0 1 005 00000000 00000000
R 12345678 0 0 12345678 1
R 9abcdef0 1 0 9abcdef0 1
C 0 0 1 005 80000011 a2000028
R 80001234 0 0 00001234 1
R 9fff0abc 0 0 1fff0abc 1
R a0003000 0 1 fe800080 0
C 0 3 1 005 80000011 a2000028
R a0003000 0 0 20003000 2
R 80001234 0 1 fe000000 0
C 0 0 1 005 00000000 00000000
T 0 00010 0 0 005 11111 1 1 3 1 22222 1 0 3 2
T 1 20000 1 1 3ff 80000 1 1 0 1 00000 0 0 0 0
T 2 20200 1 1 3ff 00000 0 0 0 0 90000 1 1 0 3
T 3 00100 0 1 000 33333 0 0 0 0 44444 1 0 0 1
R 00020abc 0 0 11111abc 1
R 00021abc 0 0 22222abc 2
R 00021004 1 1 10000800 2
R 40123456 0 0 80123456 1
R 40523456 0 0 90123456 3
R 00200010 0 1 04008000 0
R 00200010 1 1 08008000 0
R 00201010 1 1 10008000 1
C 0 0 1 006 00000000 00000000
R 00020abc 0 1 fc000800 0
R 40123456 0 0 80123456 1
C 0 3 1 006 00000000 00000000
R 00201010 1 1 1c008000 1
R 00200010 1 1 08008000 0
R 00600000 0 1 fc018000 0
C 1 3 2 006 00000000 00000000
B
R 00000100 0 0 00000100 2
R 11111111 1 0 11111111 2
R 22222222 0 0 22222222 2
R 33333333 0 0 33333333 2
Q 4
F
I a

// File: vlog.f
logic/mmu_pkg.sv
logic/tlb_entry_match.sv
logic/addr_xlate.sv
logic/xlate_buffer.sv
logic/perm_check.sv
logic/mmu_xlate_top.sv
verif/tb_clk_gen.sv
verif/mmu_xlate_chk.sv
verif/mmu_xlate_tb.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module mmu_xlate_tb -f vlog.f &&
./obj_dir/Vmmu_xlate_tb | tee /dev/stderr | grep -qx 'PASS: all tests' &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

// File: verif/mmu_xlate_tb.sv
`default_nettype none

module mmu_xlate_tb;

  import mmu_pkg::*;

  localparam string IN_FILE = "verif/xlate_input.txt";
  localparam int    TO_MARGIN = 100;

  logic        clk;
  logic        rst_i;
  logic        crmd_da_i;
  logic [1:0]  crmd_plv_i;
  logic [1:0]  crmd_datm_i;
  logic [9:0]  asid_i;
  logic [31:0] dmw0_i;
  logic [31:0] dmw1_i;
  logic        tlb_we_i;
  logic [2:0]  tlb_widx_i;
  logic [18:0] tlb_vppn_i;
  logic        tlb_ps4m_i;
  logic        tlb_g_i;
  logic [9:0]  tlb_asid_i;
  logic [19:0] tlb_ppn0_i;
  logic        tlb_v0_i;
  logic        tlb_d0_i;
  logic [1:0]  tlb_plv0_i;
  logic [1:0]  tlb_mat0_i;
  logic [19:0] tlb_ppn1_i;
  logic        tlb_v1_i;
  logic        tlb_d1_i;
  logic [1:0]  tlb_plv1_i;
  logic [1:0]  tlb_mat1_i;
  logic        req_valid_i;
  logic        req_ready_o;
  logic [31:0] req_vaddr_i;
  logic        req_store_i;
  logic        resp_valid_o;
  logic        resp_ready_i;
  logic        resp_fault_o;
  logic [1:0]  resp_mat_o;
  xlate_resp_u resp_word_o;

  // expected response packed as {fault, mat, word}
  logic [34:0] exp_q[$];
  logic [34:0] exp_head;
  logic        hold;
  int          seed = 32'hf2c60992;
  int          cycle_cnt = 0;
  int          cycle_limit = 0;

  tb_clk_gen clk_gen_i (.clk_o(clk));

  mmu_xlate_top dut_i (.*);

  task automatic stop_with_fail();
    $display("FAIL: see errors above");
    $fatal(1, "run stopped");
  endtask

  task automatic check_head();
    assert (exp_q.size() > 0) else begin
      $display("response arrived at time %0t with none expected", $time);
      stop_with_fail();
    end
    exp_head = exp_q.pop_front();
    assert (resp_fault_o == exp_head[34]) else begin
      $display("ERR t=%0t resp_fault_o got %0b exp %0b", $time, resp_fault_o, exp_head[34]);
      stop_with_fail();
    end
    assert (resp_word_o.paddr == exp_head[31:0]) else begin
      $display("ERR t=%0t resp_word_o got %h exp %h", $time, resp_word_o.paddr,
               exp_head[31:0]);
      stop_with_fail();
    end
    assert (resp_mat_o == exp_head[33:32]) else begin
      $display("ERR t=%0t resp_mat_o got %0d exp %0d", $time, resp_mat_o, exp_head[33:32]);
      stop_with_fail();
    end
  endtask

  // random ready and the response is taken at the next rising edge
  always @(negedge clk) begin
    if (rst_i || hold) begin
      resp_ready_i = 1'b0;
    end else begin
      resp_ready_i = $random(seed) & 1;
    end
    if (resp_valid_o && resp_ready_i) begin
      check_head();
    end
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_limit != 0 && cycle_cnt > cycle_limit) begin
      $display("timeout after %0d cycles, responses still missing", cycle_cnt);
      stop_with_fail();
    end
  end

  task automatic drain();
    while (exp_q.size() != 0) @(negedge clk);
    @(negedge clk);
  endtask

  task automatic send_req(input logic [31:0] va, input logic st, input logic [34:0] e);
    req_valid_i = 1'b1;
    req_vaddr_i = va;
    req_store_i = st;
    while (!req_ready_o) @(negedge clk);
    exp_q.push_back(e);
    @(negedge clk);
    req_valid_i = 1'b0;
  endtask

  task automatic write_tlb(input logic [31:0] f[16]);
    tlb_widx_i  = f[0][2:0];
    tlb_vppn_i  = f[1][18:0];
    tlb_ps4m_i  = f[2][0];
    tlb_g_i     = f[3][0];
    tlb_asid_i  = f[4][9:0];
    tlb_ppn0_i  = f[5][19:0];
    tlb_v0_i    = f[6][0];
    tlb_d0_i    = f[7][0];
    tlb_plv0_i  = f[8][1:0];
    tlb_mat0_i  = f[9][1:0];
    tlb_ppn1_i  = f[10][19:0];
    tlb_v1_i    = f[11][0];
    tlb_d1_i    = f[12][0];
    tlb_plv1_i  = f[13][1:0];
    tlb_mat1_i  = f[14][1:0];
    tlb_we_i    = 1'b1;
    @(negedge clk);
    tlb_we_i    = 1'b0;
  endtask

  initial begin
    int          fd;
    int          n_lines;
    string       line;
    string       cmd;
    logic [31:0] f[16];

    rst_i = 1'b1;
    hold = 1'b1;
    {crmd_da_i, crmd_plv_i, crmd_datm_i, asid_i, dmw0_i, dmw1_i} = '0;
    {tlb_we_i, tlb_widx_i, tlb_vppn_i, tlb_ps4m_i, tlb_g_i, tlb_asid_i} = '0;
    {tlb_ppn0_i, tlb_v0_i, tlb_d0_i, tlb_plv0_i, tlb_mat0_i} = '0;
    {tlb_ppn1_i, tlb_v1_i, tlb_d1_i, tlb_plv1_i, tlb_mat1_i} = '0;
    {req_valid_i, req_vaddr_i, req_store_i, resp_ready_i} = '0;

    // count lines to size the timeout
    n_lines = 0;
    fd = $fopen(IN_FILE, "r");
    if (fd == 0) begin
      $display("cannot open %s", IN_FILE);
      stop_with_fail();
    end
    while ($fgets(line, fd) != 0) n_lines++;
    $fclose(fd);
    cycle_limit = 20 * n_lines + TO_MARGIN;

    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_i = 1'b0;
    hold = 1'b0;

    fd = $fopen(IN_FILE, "r");
    while ($fgets(line, fd) != 0) begin
      if (line.len() < 2 || line.getc(0) == "#") continue;
      foreach (f[i]) f[i] = '0;
      void'($sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h", cmd,
                    f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10],
                    f[11], f[12], f[13], f[14], f[15]));
      case (cmd)
        "C": begin
          drain();
          crmd_da_i   = f[0][0];
          crmd_plv_i  = f[1][1:0];
          crmd_datm_i = f[2][1:0];
          asid_i      = f[3][9:0];
          dmw0_i      = f[4];
          dmw1_i      = f[5];
          @(negedge clk);
        end
        "T": write_tlb(f);
        "R": send_req(f[0], f[1][0], {f[2][0], f[4][1:0], f[3]});
        "B": hold = 1'b1;
        "Q": begin
          // every credit is used and nothing has been popped
          assert (!req_ready_o) else begin
            $display("ERR t=%0t req_ready_o got %0b exp 0", $time, req_ready_o);
            stop_with_fail();
          end
        end
        "F": hold = 1'b0;
        "I": repeat (f[0]) @(negedge clk);
        default: begin
          $display("unknown command in input file: %s", line);
          stop_with_fail();
        end
      endcase
    end
    $fclose(fd);

    drain();
    repeat (4) @(negedge clk);
    $display("PASS: all tests");
    $finish;
  end

endmodule

`default_nettype wire

// File: verif/mmu_xlate_chk.sv
`default_nettype none

module mmu_xlate_chk (
  input wire logic clk,
  input wire logic rst_i,
  input wire logic req_valid_i,
  input wire logic req_ready_i,
  input wire logic xlate_valid_i,
  input wire logic credit_ret_i,
  input wire logic resp_valid_i,
  input wire logic resp_ready_i
);

  import mmu_pkg::*;

  int outst_q;

  // accepted requests not yet popped from the buffer
  always_ff @(posedge clk) begin
    if (rst_i) begin
      outst_q <= 0;
    end else begin
      outst_q <= outst_q + int'(req_valid_i && req_ready_i) - int'(credit_ret_i);
    end
  end

  outst_bound_a: assert property (@(posedge clk) disable iff (rst_i) outst_q <= BUF_DEPTH)
    else $error("more results in flight than buffer slots");

  xlate_after_accept_a: assert property (@(posedge clk) disable iff (rst_i)
    xlate_valid_i |-> $past(req_valid_i && req_ready_i))
    else $error("translation result without an accepted request");

  resp_hold_a: assert property (@(posedge clk) disable iff (rst_i)
    (resp_valid_i && !resp_ready_i) |=> resp_valid_i)
    else $error("response withdrawn before it was taken");

endmodule

bind mmu_xlate_top mmu_xlate_chk chk_i (
  .clk           (clk),
  .rst_i         (rst_i),
  .req_valid_i   (req_valid_i),
  .req_ready_i   (req_ready_o),
  .xlate_valid_i (xlate_valid),
  .credit_ret_i  (credit_ret),
  .resp_valid_i  (resp_valid_o),
  .resp_ready_i  (resp_ready_i)
);

`default_nettype wire

// File: verif/tb_clk_gen.sv
`default_nettype none

module tb_clk_gen (
  output logic clk_o
);

  // period of 8 time units
  initial begin
    clk_o = 1'b0;
  end

  always #4 clk_o = ~clk_o;

endmodule

`default_nettype wire

// File: logic/mmu_xlate_top.sv
`default_nettype none

module mmu_xlate_top (
  input  wire logic                          clk,
  input  wire logic                          rst_i,
  input  wire logic                          crmd_da_i,
  input  wire logic [mmu_pkg::PLV_W-1:0]     crmd_plv_i,
  input  wire logic [mmu_pkg::MAT_W-1:0]     crmd_datm_i,
  input  wire logic [mmu_pkg::ASID_W-1:0]    asid_i,
  input  wire logic [31:0]                   dmw0_i,
  input  wire logic [31:0]                   dmw1_i,
  input  wire logic                          tlb_we_i,
  input  wire logic [mmu_pkg::TLB_IDX_W-1:0] tlb_widx_i,
  input  wire logic [mmu_pkg::VPPN_W-1:0]    tlb_vppn_i,
  input  wire logic                          tlb_ps4m_i,
  input  wire logic                          tlb_g_i,
  input  wire logic [mmu_pkg::ASID_W-1:0]    tlb_asid_i,
  input  wire logic [mmu_pkg::PPN_W-1:0]     tlb_ppn0_i,
  input  wire logic                          tlb_v0_i,
  input  wire logic                          tlb_d0_i,
  input  wire logic [mmu_pkg::PLV_W-1:0]     tlb_plv0_i,
  input  wire logic [mmu_pkg::MAT_W-1:0]     tlb_mat0_i,
  input  wire logic [mmu_pkg::PPN_W-1:0]     tlb_ppn1_i,
  input  wire logic                          tlb_v1_i,
  input  wire logic                          tlb_d1_i,
  input  wire logic [mmu_pkg::PLV_W-1:0]     tlb_plv1_i,
  input  wire logic [mmu_pkg::MAT_W-1:0]     tlb_mat1_i,
  input  wire logic                          req_valid_i,
  output logic                               req_ready_o,
  input  wire logic [31:0]                   req_vaddr_i,
  input  wire logic                          req_store_i,
  output logic                               resp_valid_o,
  input  wire logic                          resp_ready_i,
  output logic                               resp_fault_o,
  output logic [mmu_pkg::MAT_W-1:0]          resp_mat_o,
  output mmu_pkg::xlate_resp_u               resp_word_o
);

  import mmu_pkg::*;

  // producer to buffer
  logic              xlate_valid;
  logic              credit_ret;
  logic              x_found;
  logic [PPN_W-1:0]  x_ppn;
  logic              x_v;
  logic              x_d;
  logic [PLV_W-1:0]  x_plv;
  logic [MAT_W-1:0]  x_mat;
  logic              x_store;
  logic [VPPN_W-1:0] x_vppn;
  logic [PS_4K-1:0]  x_offs;

  // buffer head to consumer
  logic              buf_valid;
  logic              buf_pop;
  logic              h_found;
  logic [PPN_W-1:0]  h_ppn;
  logic              h_v;
  logic              h_d;
  logic [PLV_W-1:0]  h_plv;
  logic [MAT_W-1:0]  h_mat;
  logic              h_store;
  logic [VPPN_W-1:0] h_vppn;
  logic [PS_4K-1:0]  h_offs;

  addr_xlate xlate_i (
    .clk           (clk),
    .rst_i         (rst_i),
    .crmd_da_i     (crmd_da_i),
    .crmd_plv_i    (crmd_plv_i),
    .crmd_datm_i   (crmd_datm_i),
    .asid_i        (asid_i),
    .dmw0_i        (dmw0_i),
    .dmw1_i        (dmw1_i),
    .tlb_we_i      (tlb_we_i),
    .tlb_widx_i    (tlb_widx_i),
    .tlb_vppn_i    (tlb_vppn_i),
    .tlb_ps4m_i    (tlb_ps4m_i),
    .tlb_g_i       (tlb_g_i),
    .tlb_asid_i    (tlb_asid_i),
    .tlb_ppn0_i    (tlb_ppn0_i),
    .tlb_v0_i      (tlb_v0_i),
    .tlb_d0_i      (tlb_d0_i),
    .tlb_plv0_i    (tlb_plv0_i),
    .tlb_mat0_i    (tlb_mat0_i),
    .tlb_ppn1_i    (tlb_ppn1_i),
    .tlb_v1_i      (tlb_v1_i),
    .tlb_d1_i      (tlb_d1_i),
    .tlb_plv1_i    (tlb_plv1_i),
    .tlb_mat1_i    (tlb_mat1_i),
    .req_valid_i   (req_valid_i),
    .req_vaddr_i   (req_vaddr_i),
    .req_store_i   (req_store_i),
    .req_ready_o   (req_ready_o),
    .credit_ret_i  (credit_ret),
    .xlate_valid_o (xlate_valid),
    .found_o       (x_found),
    .ppn_o         (x_ppn),
    .v_o           (x_v),
    .d_o           (x_d),
    .plv_o         (x_plv),
    .mat_o         (x_mat),
    .store_o       (x_store),
    .vppn_o        (x_vppn),
    .offs_o        (x_offs)
  );

  xlate_buffer buf_i (
    .clk          (clk),
    .rst_i        (rst_i),
    .wr_i         (xlate_valid),
    .found_i      (x_found),
    .ppn_i        (x_ppn),
    .v_i          (x_v),
    .d_i          (x_d),
    .plv_i        (x_plv),
    .mat_i        (x_mat),
    .store_i      (x_store),
    .vppn_i       (x_vppn),
    .offs_i       (x_offs),
    .pop_i        (buf_pop),
    .buf_valid_o  (buf_valid),
    .found_o      (h_found),
    .ppn_o        (h_ppn),
    .v_o          (h_v),
    .d_o          (h_d),
    .plv_o        (h_plv),
    .mat_o        (h_mat),
    .store_o      (h_store),
    .vppn_o       (h_vppn),
    .offs_o       (h_offs),
    .credit_ret_o (credit_ret)
  );

  perm_check perm_i (
    .buf_valid_i  (buf_valid),
    .found_i      (h_found),
    .ppn_i        (h_ppn),
    .v_i          (h_v),
    .d_i          (h_d),
    .plv_i        (h_plv),
    .mat_i        (h_mat),
    .store_i      (h_store),
    .vppn_i       (h_vppn),
    .offs_i       (h_offs),
    .crmd_plv_i   (crmd_plv_i),
    .resp_ready_i (resp_ready_i),
    .pop_o        (buf_pop),
    .resp_valid_o (resp_valid_o),
    .resp_fault_o (resp_fault_o),
    .resp_mat_o   (resp_mat_o),
    .resp_word_o  (resp_word_o)
  );

endmodule

`default_nettype wire

// File: logic/perm_check.sv
`default_nettype none

module perm_check (
  input  wire logic                       buf_valid_i,
  input  wire logic                       found_i,
  input  wire logic [mmu_pkg::PPN_W-1:0]  ppn_i,
  input  wire logic                       v_i,
  input  wire logic                       d_i,
  input  wire logic [mmu_pkg::PLV_W-1:0]  plv_i,
  input  wire logic [mmu_pkg::MAT_W-1:0]  mat_i,
  input  wire logic                       store_i,
  input  wire logic [mmu_pkg::VPPN_W-1:0] vppn_i,
  input  wire logic [mmu_pkg::PS_4K-1:0]  offs_i,
  input  wire logic [mmu_pkg::PLV_W-1:0]  crmd_plv_i,
  input  wire logic                       resp_ready_i,
  output logic                            pop_o,
  output logic                            resp_valid_o,
  output logic                            resp_fault_o,
  output logic [mmu_pkg::MAT_W-1:0]       resp_mat_o,
  output mmu_pkg::xlate_resp_u            resp_word_o
);

  import mmu_pkg::*;

  logic       fault;
  logic [5:0] ecode;

  // first failing check wins
  always_comb begin
    fault = 1'b1;
    ecode = ECODE_TLBR;
    if (!found_i) begin
      ecode = ECODE_TLBR;
    end else if (!v_i) begin
      ecode = store_i ? ECODE_PIS : ECODE_PIL;
    end else if (crmd_plv_i > plv_i) begin
      ecode = ECODE_PPI;
    end else if (store_i && !d_i) begin
      ecode = ECODE_PME;
    end else begin
      fault = 1'b0;
    end
  end

  always_comb begin
    resp_word_o = '0;
    if (fault) begin
      resp_word_o.fault.ecode   = ecode;
      resp_word_o.fault.badvppn = vppn_i;
    end else begin
      resp_word_o.paddr = {ppn_i, offs_i};
    end
  end

  assign resp_valid_o = buf_valid_i;
  assign resp_fault_o = fault;
  assign resp_mat_o   = mat_i;
  assign pop_o        = buf_valid_i && resp_ready_i;

endmodule

`default_nettype wire

// File: logic/xlate_buffer.sv
`default_nettype none

module xlate_buffer (
  input  wire logic                       clk,
  input  wire logic                       rst_i,
  input  wire logic                       wr_i,
  input  wire logic                       found_i,
  input  wire logic [mmu_pkg::PPN_W-1:0]  ppn_i,
  input  wire logic                       v_i,
  input  wire logic                       d_i,
  input  wire logic [mmu_pkg::PLV_W-1:0]  plv_i,
  input  wire logic [mmu_pkg::MAT_W-1:0]  mat_i,
  input  wire logic                       store_i,
  input  wire logic [mmu_pkg::VPPN_W-1:0] vppn_i,
  input  wire logic [mmu_pkg::PS_4K-1:0]  offs_i,
  input  wire logic                       pop_i,
  output logic                            buf_valid_o,
  output logic                            found_o,
  output logic [mmu_pkg::PPN_W-1:0]       ppn_o,
  output logic                            v_o,
  output logic                            d_o,
  output logic [mmu_pkg::PLV_W-1:0]       plv_o,
  output logic [mmu_pkg::MAT_W-1:0]       mat_o,
  output logic                            store_o,
  output logic [mmu_pkg::VPPN_W-1:0]      vppn_o,
  output logic [mmu_pkg::PS_4K-1:0]       offs_o,
  output logic                            credit_ret_o
);

  import mmu_pkg::*;

  logic [BUF_PTR_W-1:0] wr_ptr_q;
  logic [BUF_PTR_W-1:0] rd_ptr_q;
  logic [CREDIT_W-1:0]  cnt_q;
  logic                 do_pop;

  logic             found_m [BUF_DEPTH];
  logic [PPN_W-1:0] ppn_m   [BUF_DEPTH];
  logic             v_m     [BUF_DEPTH];
  logic             d_m     [BUF_DEPTH];
  logic [PLV_W-1:0] plv_m   [BUF_DEPTH];
  logic [MAT_W-1:0] mat_m   [BUF_DEPTH];
  logic             store_m [BUF_DEPTH];
  logic [VPPN_W-1:0] vppn_m [BUF_DEPTH];
  logic [PS_4K-1:0] offs_m  [BUF_DEPTH];

  assign buf_valid_o  = (cnt_q != '0);
  assign do_pop       = pop_i && buf_valid_o;
  assign credit_ret_o = do_pop;

  // no full check, producer credits keep a slot free
  always_ff @(posedge clk) begin
    if (wr_i) begin
      found_m[wr_ptr_q] <= found_i;
      ppn_m[wr_ptr_q]   <= ppn_i;
      v_m[wr_ptr_q]     <= v_i;
      d_m[wr_ptr_q]     <= d_i;
      plv_m[wr_ptr_q]   <= plv_i;
      mat_m[wr_ptr_q]   <= mat_i;
      store_m[wr_ptr_q] <= store_i;
      vppn_m[wr_ptr_q]  <= vppn_i;
      offs_m[wr_ptr_q]  <= offs_i;
    end
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (wr_i) begin
        wr_ptr_q <= (wr_ptr_q == BUF_PTR_W'(BUF_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == BUF_PTR_W'(BUF_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      cnt_q <= cnt_q + CREDIT_W'(wr_i) - CREDIT_W'(do_pop);
    end
  end

  // head of queue
  assign found_o = found_m[rd_ptr_q];
  assign ppn_o   = ppn_m[rd_ptr_q];
  assign v_o     = v_m[rd_ptr_q];
  assign d_o     = d_m[rd_ptr_q];
  assign plv_o   = plv_m[rd_ptr_q];
  assign mat_o   = mat_m[rd_ptr_q];
  assign store_o = store_m[rd_ptr_q];
  assign vppn_o  = vppn_m[rd_ptr_q];
  assign offs_o  = offs_m[rd_ptr_q];

endmodule

`default_nettype wire

// File: logic/addr_xlate.sv
`default_nettype none

module addr_xlate (
  input  wire logic                       clk,
  input  wire logic                       rst_i,
  input  wire logic                       crmd_da_i,
  input  wire logic [mmu_pkg::PLV_W-1:0]  crmd_plv_i,
  input  wire logic [mmu_pkg::MAT_W-1:0]  crmd_datm_i,
  input  wire logic [mmu_pkg::ASID_W-1:0] asid_i,
  input  wire logic [31:0]                dmw0_i,
  input  wire logic [31:0]                dmw1_i,
  input  wire logic                          tlb_we_i,
  input  wire logic [mmu_pkg::TLB_IDX_W-1:0] tlb_widx_i,
  input  wire logic [mmu_pkg::VPPN_W-1:0]    tlb_vppn_i,
  input  wire logic                          tlb_ps4m_i,
  input  wire logic                          tlb_g_i,
  input  wire logic [mmu_pkg::ASID_W-1:0]    tlb_asid_i,
  input  wire logic [mmu_pkg::PPN_W-1:0]     tlb_ppn0_i,
  input  wire logic                          tlb_v0_i,
  input  wire logic                          tlb_d0_i,
  input  wire logic [mmu_pkg::PLV_W-1:0]     tlb_plv0_i,
  input  wire logic [mmu_pkg::MAT_W-1:0]     tlb_mat0_i,
  input  wire logic [mmu_pkg::PPN_W-1:0]     tlb_ppn1_i,
  input  wire logic                          tlb_v1_i,
  input  wire logic                          tlb_d1_i,
  input  wire logic [mmu_pkg::PLV_W-1:0]     tlb_plv1_i,
  input  wire logic [mmu_pkg::MAT_W-1:0]     tlb_mat1_i,
  input  wire logic                       req_valid_i,
  input  wire logic [31:0]                req_vaddr_i,
  input  wire logic                       req_store_i,
  output logic                            req_ready_o,
  input  wire logic                       credit_ret_i,
  output logic                            xlate_valid_o,
  output logic                            found_o,
  output logic [mmu_pkg::PPN_W-1:0]       ppn_o,
  output logic                            v_o,
  output logic                            d_o,
  output logic [mmu_pkg::PLV_W-1:0]       plv_o,
  output logic [mmu_pkg::MAT_W-1:0]       mat_o,
  output logic                            store_o,
  output logic [mmu_pkg::VPPN_W-1:0]      vppn_o,
  output logic [mmu_pkg::PS_4K-1:0]       offs_o
);

  import mmu_pkg::*;

  logic [CREDIT_W-1:0]  credit_q;
  logic                 accept;
  logic [TLB_ENTRIES-1:0] tlb_match;
  logic [TLB_ENTRIES-1:0] tlb_ps4m;
  logic [TLB_ENTRIES-1:0] tlb_odd;
  logic [1:0]           dmw_hit;
  logic [31:0]          dmw_sel;

  // page values, even page in slot 0
  logic [PPN_W-1:0] pg_ppn [TLB_ENTRIES][2];
  logic             pg_v   [TLB_ENTRIES][2];
  logic             pg_d   [TLB_ENTRIES][2];
  logic [PLV_W-1:0] pg_plv [TLB_ENTRIES][2];
  logic [MAT_W-1:0] pg_mat [TLB_ENTRIES][2];

  logic             tlb_hit;
  logic             tlb_4m;
  logic [PPN_W-1:0] tlb_ppn;
  logic             tlb_v;
  logic             tlb_d;
  logic [PLV_W-1:0] tlb_plv;
  logic [MAT_W-1:0] tlb_mat;

  logic             res_found;
  logic [PPN_W-1:0] res_ppn;
  logic             res_v;
  logic             res_d;
  logic [PLV_W-1:0] res_plv;
  logic [MAT_W-1:0] res_mat;

  for (genvar i = 0; i < TLB_ENTRIES; i++) begin : g_entry
    tlb_entry_match entry_i (
      .clk       (clk),
      .rst_i     (rst_i),
      .we_i      (tlb_we_i && (tlb_widx_i == TLB_IDX_W'(i))),
      .vppn_i    (tlb_vppn_i),
      .ps4m_i    (tlb_ps4m_i),
      .g_i       (tlb_g_i),
      .asid_i    (tlb_asid_i),
      .lk_vppn_i (req_vaddr_i[31:13]),
      .lk_asid_i (asid_i),
      .match_o   (tlb_match[i]),
      .ps4m_o    (tlb_ps4m[i])
    );
    // even/odd page select bit follows the page size
    assign tlb_odd[i] = tlb_ps4m[i] ? req_vaddr_i[PS_4M] : req_vaddr_i[PS_4K];
  end

  always_ff @(posedge clk) begin
    if (tlb_we_i) begin
      pg_ppn[tlb_widx_i][0] <= tlb_ppn0_i;
      pg_v[tlb_widx_i][0]   <= tlb_v0_i;
      pg_d[tlb_widx_i][0]   <= tlb_d0_i;
      pg_plv[tlb_widx_i][0] <= tlb_plv0_i;
      pg_mat[tlb_widx_i][0] <= tlb_mat0_i;
      pg_ppn[tlb_widx_i][1] <= tlb_ppn1_i;
      pg_v[tlb_widx_i][1]   <= tlb_v1_i;
      pg_d[tlb_widx_i][1]   <= tlb_d1_i;
      pg_plv[tlb_widx_i][1] <= tlb_plv1_i;
      pg_mat[tlb_widx_i][1] <= tlb_mat1_i;
    end
  end

  // match vector is one-hot, so or-reduce the selected values
  always_comb begin
    tlb_hit = 1'b0;
    tlb_4m  = 1'b0;
    tlb_ppn = '0;
    tlb_v   = 1'b0;
    tlb_d   = 1'b0;
    tlb_plv = '0;
    tlb_mat = '0;
    for (int i = 0; i < TLB_ENTRIES; i++) begin
      if (tlb_match[i]) begin
        tlb_hit = 1'b1;
        tlb_4m  = tlb_4m | tlb_ps4m[i];
        tlb_ppn = tlb_ppn | pg_ppn[i][tlb_odd[i]];
        tlb_v   = tlb_v | pg_v[i][tlb_odd[i]];
        tlb_d   = tlb_d | pg_d[i][tlb_odd[i]];
        tlb_plv = tlb_plv | pg_plv[i][tlb_odd[i]];
        tlb_mat = tlb_mat | pg_mat[i][tlb_odd[i]];
      end
    end
  end

  // window hit needs vseg match and the plv bit of the current level
  assign dmw_hit[0] = (dmw0_i[31:29] == req_vaddr_i[31:29]) && dmw0_i[crmd_plv_i];
  assign dmw_hit[1] = (dmw1_i[31:29] == req_vaddr_i[31:29]) && dmw1_i[crmd_plv_i];
  assign dmw_sel    = dmw_hit[0] ? dmw0_i : dmw1_i;

  // direct mode, then windows, then tlb
  always_comb begin
    res_found = 1'b1;
    res_v     = 1'b1;
    res_d     = 1'b1;
    res_plv   = 2'd3;
    if (crmd_da_i) begin
      res_ppn = req_vaddr_i[31:PS_4K];
      res_mat = crmd_datm_i;
    end else if (|dmw_hit) begin
      res_ppn = {dmw_sel[27:25], req_vaddr_i[28:PS_4K]};
      res_mat = dmw_sel[5:4];
    end else begin
      res_found = tlb_hit;
      res_v     = tlb_v;
      res_d     = tlb_d;
      res_plv   = tlb_plv;
      res_mat   = tlb_mat;
      // 4M page takes its low ppn bits from the vaddr
      res_ppn   = tlb_4m ? {tlb_ppn[PPN_W-1:PS_4M-PS_4K], req_vaddr_i[PS_4M-1:PS_4K]}
                         : tlb_ppn;
    end
  end

  assign req_ready_o = (credit_q != '0);
  assign accept      = req_valid_i && req_ready_o;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      credit_q      <= CREDIT_W'(BUF_DEPTH);
      xlate_valid_o <= 1'b0;
    end else begin
      credit_q      <= credit_q - CREDIT_W'(accept) + CREDIT_W'(credit_ret_i);
      xlate_valid_o <= accept;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      found_o <= res_found;
      ppn_o   <= res_ppn;
      v_o     <= res_v;
      d_o     <= res_d;
      plv_o   <= res_plv;
      mat_o   <= res_mat;
      store_o <= req_store_i;
      vppn_o  <= req_vaddr_i[31:13];
      offs_o  <= req_vaddr_i[PS_4K-1:0];
    end
  end

endmodule

`default_nettype wire

// File: logic/tlb_entry_match.sv
`default_nettype none

module tlb_entry_match (
  input  wire logic                      clk,
  input  wire logic                      rst_i,
  input  wire logic                      we_i,
  input  wire logic [mmu_pkg::VPPN_W-1:0] vppn_i,
  input  wire logic                      ps4m_i,
  input  wire logic                      g_i,
  input  wire logic [mmu_pkg::ASID_W-1:0] asid_i,
  input  wire logic [mmu_pkg::VPPN_W-1:0] lk_vppn_i,
  input  wire logic [mmu_pkg::ASID_W-1:0] lk_asid_i,
  output logic                           match_o,
  output logic                           ps4m_o
);

  logic                      valid_q;
  logic [mmu_pkg::VPPN_W-1:0] vppn_q;
  logic                      ps4m_q;
  logic                      g_q;
  logic [mmu_pkg::ASID_W-1:0] asid_q;
  logic                      vppn_hit;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      valid_q <= 1'b0;
    end else if (we_i) begin
      valid_q <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (we_i) begin
      vppn_q <= vppn_i;
      ps4m_q <= ps4m_i;
      g_q    <= g_i;
      asid_q <= asid_i;
    end
  end

  // a 4M entry covers 2^9 vppn values, so low 9 bits are don't-care
  assign vppn_hit = ps4m_q ? (vppn_q[18:9] == lk_vppn_i[18:9]) : (vppn_q == lk_vppn_i);
  assign match_o  = valid_q && vppn_hit && (g_q || (asid_q == lk_asid_i));
  assign ps4m_o   = ps4m_q;

endmodule

`default_nettype wire

// File: logic/mmu_pkg.sv
`default_nettype none

package mmu_pkg;

  // tlb geometry
  localparam int TLB_ENTRIES = 8;
  localparam int TLB_IDX_W   = $clog2(TLB_ENTRIES);

  // result buffer, also the credit pool size
  localparam int BUF_DEPTH = 4;
  localparam int BUF_PTR_W = $clog2(BUF_DEPTH);
  localparam int CREDIT_W  = $clog2(BUF_DEPTH + 1);

  // page size codes (log2 of page bytes)
  localparam int PS_4K = 12;
  localparam int PS_4M = 22;

  // field widths
  localparam int PPN_W  = 20;
  localparam int VPPN_W = 19;
  localparam int ASID_W = 10;
  localparam int PLV_W  = 2;
  localparam int MAT_W  = 2;

  // exception codes
  localparam logic [5:0] ECODE_TLBR = 6'h3f;
  localparam logic [5:0] ECODE_PIL  = 6'h01;
  localparam logic [5:0] ECODE_PIS  = 6'h02;
  localparam logic [5:0] ECODE_PME  = 6'h04;
  localparam logic [5:0] ECODE_PPI  = 6'h07;

  // response word, address on success, code and page on a fault
  typedef union packed {
    logic [31:0] paddr;
    struct packed {
      logic [5:0]        ecode;
      logic [VPPN_W-1:0] badvppn;
      logic [6:0]        zero;
    } fault;
  } xlate_resp_u;

endpackage

`default_nettype wire
